//--- bench/pipe_chk.sv
// Concurrent checks on the stall vector and the Wishbone fetch port
// Bound into pipe_top, every check is idle while rst is high
`timescale 1ns/1ps

module pipe_chk
    import pipe_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic [NUM_STAGES-1:0] stage_ready,
    input logic [NUM_STAGES-1:0] stage_stall,
    input wb_req_t               wb_req,
    input wb_rsp_t               wb_rsp
);

    // A stage that is not ready is stalled
    a_not_ready_stalls: assert property (@(posedge clk) disable iff (rst)
        (~stage_ready & ~stage_stall) == '0)
        else $error("stage not ready but not stalled");

    // A stall in a later stage holds every earlier one
    a_stall_backward: assert property (@(posedge clk) disable iff (rst)
        ((stage_stall >> 1) & ~stage_stall) == '0)
        else $error("later stage stalled while earlier stage runs");

    a_stall_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(stage_stall))
        else $error("stage_stall has unknown bits");

    // Request stays up with a steady address until ack
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=>
        (wb_req.cyc && wb_req.stb && $stable(wb_req.adr)))
        else $error("Wishbone request dropped or moved before ack");

endmodule

bind pipe_top pipe_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .stage_ready (stage_ready),
    .stage_stall (stage_stall),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp)
);

//--- bench/pipe_tb.sv
// Directed testbench for pipe_top with a Wishbone read-only memory model
// Memory answers after 0 to 3 wait states that an LFSR draws when enabled
// Expected retires come from a program interpreter with all registers at zero
// Programs must end in HALT within MEM_WORDS words
`timescale 1ns/1ps

module pipe_tb
    import pipe_pkg::*;
;

    localparam logic [IADR_W-1:0] FETCH_BASE     = 16'h0040;
    localparam int                MUL_STEP       = 4;
    localparam int                MEM_WORDS      = 32;
    localparam int                RESET_CYCLES   = 16;
    localparam int                MAX_PROG       = 16;
    localparam int                NUM_TESTS      = 6;
    localparam int                TIMEOUT_CYCLES = MAX_PROG * (3 + 3 + 32) * NUM_TESTS;

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    retire_t     retire;
    logic        halted;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog [$];
    retire_t     exp_q [$];
    logic [15:0] req_adr [$];
    logic [15:0] lfsr;
    logic        use_rand;
    int          halt_idx;
    int          checks;
    int          errors;
    int          cycles;

    pipe_top #(
        .FETCH_BASE (FETCH_BASE),
        .MUL_STEP   (MUL_STEP)
    ) UUT (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .retire (retire),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [31:0] encode(input opcode_e op, input int rd, input int rs1,
                                           input int rs2, input int imm);
        instr_t ins;
        ins     = '0;
        ins.op  = op;
        ins.rd  = reg_idx_t'(rd);
        ins.rs1 = reg_idx_t'(rs1);
        ins.rs2 = reg_idx_t'(rs2);
        ins.imm = 16'(imm);
        return ins;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
        end
    endtask

    // Interprets prog up to HALT and queues the register writes in order
    task automatic build_expected();
        logic [31:0] regs [8];
        instr_t      ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        bit          writes;
        int          i;
        exp_q.delete();
        halt_idx = -1;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        i = 0;
        while (i < prog.size() && halt_idx < 0) begin
            ins    = prog[i];
            a      = regs[ins.rs1];
            b      = regs[ins.rs2];
            writes = 1'b1;
            v      = '0;
            case (ins.op)
                OP_LI:   v = {16'h0000, ins.imm};
                OP_ADD:  v = a + b;
                OP_SUB:  v = a - b;
                OP_AND:  v = a & b;
                OP_XOR:  v = a ^ b;
                OP_MUL:  v = a * b;
                OP_HALT: begin
                    halt_idx = i;
                    writes   = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes) begin
                regs[ins.rd] = v;
                exp_q.push_back({1'b1, ins.rd, v});
            end
            i++;
        end
    endtask

    // Unused words hold an LI to r7 of their own address
    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = encode(OP_LI, 7, 0, 0, int'(FETCH_BASE) + i);
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        req_adr.delete();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_equal("retire.valid", retire.valid, 1'b0);
            check_equal("halted", halted, 1'b0);
            check_equal("wb_req.cyc", wb_req.cyc, 1'b0);
            check_equal("stage_stall", UUT.stage_stall, 3'b111);
        end
        rst = 1'b0;
        @(negedge clk);
        // First request goes out on the first edge after reset
        check_equal("wb_req.cyc", wb_req.cyc, 1'b1);
        check_equal("wb_req.stb", wb_req.stb, 1'b1);
        check_equal("wb_req.adr", wb_req.adr, FETCH_BASE);
        check_equal("retire.valid", retire.valid, 1'b0);
        check_equal("halted", halted, 1'b0);
    endtask

    task automatic run_program(input logic rand_waits);
        use_rand = rand_waits;
        build_expected();
        load_memory();
        apply_reset();
        while (!halted) begin
            @(negedge clk);
        end
        // Halted stays high with no retire and an idle bus
        repeat (20) begin
            @(negedge clk);
            check_equal("halted", halted, 1'b1);
            check_equal("wb_req.cyc", wb_req.cyc, 1'b0);
            check_equal("retire.valid", retire.valid, 1'b0);
        end
        check_equal("pending retires", exp_q.size(), 0);
        check_equal("request count", req_adr.size(), halt_idx + 1);
        foreach (req_adr[i]) begin
            check_equal("wb_req.adr", req_adr[i], FETCH_BASE + 16'(i));
        end
    endtask

    task automatic test_reset();
        prog.delete();
        prog.push_back(encode(OP_LI, 1, 0, 0, 16'h1234));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        run_program(1'b0);
    endtask

    task automatic test_independent_alu();
        prog.delete();
        prog.push_back(encode(OP_LI, 1, 0, 0, 16'h1234));
        prog.push_back(encode(OP_LI, 2, 0, 0, 16'hf0f0));
        prog.push_back(encode(OP_LI, 3, 0, 0, 16'h00ff));
        prog.push_back(encode(OP_LI, 4, 0, 0, 16'h8001));
        prog.push_back(encode(OP_NOP, 0, 0, 0, 0));
        prog.push_back(encode(OP_ADD, 5, 1, 2, 0));
        prog.push_back(encode(OP_SUB, 6, 3, 4, 0));
        prog.push_back(encode(OP_AND, 7, 1, 2, 0));
        prog.push_back(encode(OP_XOR, 0, 3, 1, 0));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        run_program(1'b0);
    endtask

    // Each instruction reads the one just before it
    // The MUL up front lets the fetch buffer fill so the ALU ops behind it
    // reach decode back to back and each one meets the hazard bubble
    task automatic load_dependent_chain();
        prog.delete();
        prog.push_back(encode(OP_LI, 1, 0, 0, 5));
        prog.push_back(encode(OP_MUL, 2, 1, 1, 0));
        prog.push_back(encode(OP_SUB, 3, 2, 1, 0));
        prog.push_back(encode(OP_XOR, 4, 3, 2, 0));
        prog.push_back(encode(OP_AND, 5, 4, 4, 0));
        prog.push_back(encode(OP_ADD, 5, 5, 5, 0));
        prog.push_back(encode(OP_SUB, 6, 0, 5, 0));
        prog.push_back(encode(OP_ADD, 6, 6, 6, 0));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
    endtask

    task automatic test_dependent_chain();
        load_dependent_chain();
        run_program(1'b0);
    endtask

    task automatic test_multiply();
        prog.delete();
        prog.push_back(encode(OP_LI, 1, 0, 0, 16'hffff));
        prog.push_back(encode(OP_LI, 2, 0, 0, 16'h8001));
        prog.push_back(encode(OP_MUL, 3, 1, 2, 0));
        prog.push_back(encode(OP_MUL, 4, 3, 3, 0));
        prog.push_back(encode(OP_MUL, 5, 4, 1, 0));
        prog.push_back(encode(OP_ADD, 6, 5, 3, 0));
        prog.push_back(encode(OP_MUL, 7, 6, 6, 0));
        prog.push_back(encode(OP_ADD, 0, 7, 1, 0));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        run_program(1'b0);
    endtask

    task automatic test_random_waits();
        load_dependent_chain();
        run_program(1'b1);
    endtask

    // Words after HALT must never be fetched
    task automatic test_halt();
        prog.delete();
        prog.push_back(encode(OP_LI, 1, 0, 0, 7));
        prog.push_back(encode(OP_ADD, 2, 1, 1, 0));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        prog.push_back(encode(OP_LI, 3, 0, 0, 16'h5555));
        prog.push_back(encode(OP_ADD, 4, 2, 2, 0));
        run_program(1'b0);
    endtask

    // Wishbone classic slave that holds ack for one cycle
    initial begin : memory_model
        int waits;
        int idx;
        bit busy;
        wb_rsp = '0;
        busy   = 1'b0;
        waits  = 0;
        forever begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                wb_rsp.ack = 1'b0;
                busy       = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = use_rand ? random_bits(2) : 0;
                end
                if (waits == 0) begin
                    idx = int'(wb_req.adr) - int'(FETCH_BASE);
                    if (idx < 0 || idx >= MEM_WORDS) begin
                        errors++;
                        $display("Fetch from 0x%04h lies outside the memory model", wb_req.adr);
                        wb_rsp.dat = '0;
                    end else begin
                        wb_rsp.dat = mem[idx];
                    end
                    wb_rsp.ack = 1'b1;
                    req_adr.push_back(wb_req.adr);
                end else begin
                    waits--;
                end
            end
        end
    end

    // Retire monitor comparing in program order
    initial begin : retire_monitor
        retire_t want;
        forever begin
            @(negedge clk);
            if (retire.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected retire to r%0d with value 0x%08h at %0t",
                             retire.rd, retire.value, $time);
                end else begin
                    want = exp_q.pop_front();
                    check_equal("retire.rd", retire.rd, want.rd);
                    check_equal("retire.value", retire.value, want.value);
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the pipeline never reached halt", cycles);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        use_rand = 1'b0;
        lfsr     = 16'd9;
        checks   = 0;
        errors   = 0;
        halt_idx = -1;
        test_reset();
        test_independent_alu();
        test_dependent_chain();
        test_multiply();
        test_random_waits();
        test_halt();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- common/pipe_pkg.sv
// Shared constants, opcodes and stage-to-stage structs for the pipeline
// Eight registers of XLEN bits; instruction words are always 32 bits
// The Wishbone port only reads, so the write enable is not carried
package pipe_pkg;

    // Layout of the stall, ready and hazard vectors
    localparam int NUM_STAGES = 3;
    localparam int STAGE_IF   = 0;
    localparam int STAGE_ID   = 1;
    localparam int STAGE_EX   = 2;

    // Datapath width and Wishbone word-address width
    localparam int XLEN   = 32;
    localparam int IADR_W = 16;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LI   = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_XOR  = 4'd5,
        OP_MUL  = 4'd6,
        OP_HALT = 4'd7
    } opcode_e;

    // Reserved bits are ignored by decode
    typedef struct packed {
        opcode_e     op;     // 31:28
        logic        rsvd0;
        reg_idx_t    rd;     // 26:24
        logic        rsvd1;
        reg_idx_t    rs1;    // 22:20
        logic        rsvd2;
        reg_idx_t    rs2;    // 18:16
        logic [15:0] imm;    // zero-extended by LI
    } instr_t;

    // Master side of the fetch bus
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [IADR_W-1:0] adr;
    } wb_req_t;

    // Slave side of the fetch bus
    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } fetch_out_t;

    typedef struct packed {
        logic            valid;
        opcode_e         op;
        reg_idx_t        rd;
        logic            wr;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } dec_out_t;

    // Destination of the instruction now in execute
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
    } dest_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        logic [XLEN-1:0] value;
    } retire_t;

endpackage

//--- decode/decode_stage.sv
// Decode stage: fetch-to-decode register, operand read and RAW hazard check
// No forwarding from execute, a source matching ex_dest raises the hazard
// Results reach decode one cycle after execute via the register file bypass
// Reset opens the register file write port for the clear sweep from execute
`timescale 1ns/1ps

module decode_stage
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  fetch_out_t fetch_in,
    input  logic       stall_if,
    input  logic       stall_id,
    input  dest_t      ex_dest,
    input  retire_t    wr,
    output dec_out_t   dec_out,
    output logic       hazard
);

    fetch_out_t      fd_q;
    opcode_e         op;
    logic            uses_src;
    logic            writes_rd;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    retire_t         rf_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            fd_q.valid <= 1'b0;
        end else if (!stall_id) begin
            // Stalled fetch hands over a bubble
            fd_q.valid <= fetch_in.valid && !stall_if;
        end
        if (!stall_id) begin
            fd_q.instr <= fetch_in.instr;
        end
    end

    assign op = fd_q.instr.op;

    // Source use and register write per opcode
    always_comb begin
        uses_src  = 1'b0;
        writes_rd = 1'b0;
        case (op)
            OP_LI: writes_rd = 1'b1;
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL: begin
                uses_src  = 1'b1;
                writes_rd = 1'b1;
            end
            default: uses_src = 1'b0;
        endcase
    end

    always_comb begin
        rf_wr       = wr;
        rf_wr.valid = wr.valid || rst;
    end

    reg_file u_reg_file (
        .clk (clk),
        .rs1 (fd_q.instr.rs1),
        .rs2 (fd_q.instr.rs2),
        .rd1 (rd1),
        .rd2 (rd2),
        .wr  (rf_wr)
    );

    assign dec_out.valid = fd_q.valid;
    assign dec_out.op    = op;
    assign dec_out.rd    = fd_q.instr.rd;
    assign dec_out.wr    = writes_rd;
    assign dec_out.a     = rd1;
    // LI carries its zero-extended immediate as the second operand
    assign dec_out.b     = (op == OP_LI) ? {{(XLEN-16){1'b0}}, fd_q.instr.imm} : rd2;

    // Unforwardable RAW on the instruction sitting in execute
    assign hazard = fd_q.valid && uses_src && ex_dest.valid &&
                    (fd_q.instr.rs1 == ex_dest.rd || fd_q.instr.rs2 == ex_dest.rd);

endmodule

//--- execute/exec_stage.sv
// Execute stage: decode-to-execute register, ALU, multiplier, writeback register
// MUL_STEP is 1, 2, 4 or 8; a MUL spends XLEN/MUL_STEP cycles in execute
// Results are modulo 2**XLEN, MUL keeps the low XLEN bits of the product
// In reset the writeback register sweeps rd with zero data to clear registers
`timescale 1ns/1ps

module exec_stage
    import pipe_pkg::*;
#(
    parameter int MUL_STEP = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  dec_out_t dec_in,
    input  logic     stall_id,
    input  logic     stall_ex,
    output logic     ready,
    output dest_t    ex_dest,
    output retire_t  retire,
    output logic     halted
);

    localparam int MUL_CYC = XLEN / MUL_STEP;
    localparam int CNT_W   = $clog2(MUL_CYC);

    typedef enum logic {
        S_IDLE,
        S_MUL
    } mul_state_e;

    dec_out_t         ex_q;
    mul_state_e       state;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  acc_q;
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [XLEN-1:0]  cur_acc;
    logic [XLEN-1:0]  cur_mcand;
    logic [XLEN-1:0]  cur_mplier;
    logic [XLEN-1:0]  step_acc;
    logic [XLEN-1:0]  result;
    logic             is_mul;
    logic             mul_last;
    logic             leave;
    logic             rst_q;

    always_ff @(posedge clk) begin
        if (!stall_ex) begin
            ex_q <= dec_in;
        end
        if (rst) begin
            ex_q.valid <= 1'b0;
        end else if (!stall_ex) begin
            ex_q.valid <= dec_in.valid && !stall_id;
        end
    end

    assign is_mul   = ex_q.valid && ex_q.op == OP_MUL;
    assign mul_last = (state == S_MUL) && (cnt_q == CNT_W'(MUL_CYC - 1));
    assign leave    = ex_q.valid && !stall_ex;
    // Not ready mid-multiply, and while the reset clear sweep runs
    assign ready    = !rst_q && !(is_mul && !mul_last);

    assign ex_dest.valid = ex_q.valid && ex_q.wr;
    assign ex_dest.rd    = ex_q.rd;

    // One shift-add step, the first one taken straight from the operands
    always_comb begin
        cur_acc    = (state == S_IDLE) ? '0 : acc_q;
        cur_mcand  = (state == S_IDLE) ? ex_q.a : mcand_q;
        cur_mplier = (state == S_IDLE) ? ex_q.b : mplier_q;
        step_acc   = cur_acc;
        for (int i = 0; i < MUL_STEP; i++) begin
            if (cur_mplier[i]) begin
                step_acc = step_acc + (cur_mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt_q <= '0;
        end else if (state == S_IDLE) begin
            if (is_mul) begin
                state <= S_MUL;
                cnt_q <= CNT_W'(1);
            end
        end else if (mul_last) begin
            state <= S_IDLE;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
        acc_q    <= step_acc;
        mcand_q  <= cur_mcand << MUL_STEP;
        mplier_q <= cur_mplier >> MUL_STEP;
    end

    always_comb begin
        case (ex_q.op)
            OP_LI:   result = ex_q.b;
            OP_ADD:  result = ex_q.a + ex_q.b;
            OP_SUB:  result = ex_q.a - ex_q.b;
            OP_AND:  result = ex_q.a & ex_q.b;
            OP_XOR:  result = ex_q.a ^ ex_q.b;
            OP_MUL:  result = step_acc;
            default: result = '0;
        endcase
    end

    // Writeback register, retire feeds the register file on the next edge
    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            retire.valid <= 1'b0;
            retire.value <= '0;
            halted       <= 1'b0;
            // Sweep index restarts at zero on the first reset edge
            if (rst_q) begin
                retire.rd <= retire.rd + 1'b1;
            end else begin
                retire.rd <= '0;
            end
        end else begin
            retire.valid <= leave && ex_q.wr;
            retire.rd    <= ex_q.rd;
            retire.value <= result;
            if (leave && ex_q.op == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- fetch/fetch_unit.sv
// Wishbone classic fetch master, read cycles only, one request at a time
// Word addresses count up by one from FETCH_BASE, there are no branches
// A new request starts only when the holding buffer is empty or draining
// After a HALT word is fetched no further requests are made until reset
`timescale 1ns/1ps

module fetch_unit
    import pipe_pkg::*;
#(
    parameter logic [IADR_W-1:0] FETCH_BASE = '0
) (
    input  logic       clk,
    input  logic       rst,
    output wb_req_t    wb_req,
    input  wb_rsp_t    wb_rsp,
    input  logic       stall_if,
    input  logic       id_stall,
    output logic       ready,
    output fetch_out_t fetch_out
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_HALTED
    } fetch_state_e;

    fetch_state_e      state;
    logic [IADR_W-1:0] adr_q;
    logic              buf_valid;
    instr_t            buf_instr;
    instr_t            rsp_instr;
    logic              buf_free;
    logic              take;

    assign rsp_instr = wb_rsp.dat;
    assign take      = (state == S_REQ) && wb_rsp.ack;

    // Buffer empty, or its word moves into decode on this edge
    assign buf_free = !buf_valid || !id_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            adr_q <= FETCH_BASE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (buf_free) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    // cyc and stb drop on the edge after ack
                    if (wb_rsp.ack) begin
                        adr_q <= adr_q + 1'b1;
                        state <= (rsp_instr.op == OP_HALT) ? S_HALTED : S_IDLE;
                    end
                end
                default: state <= S_HALTED;
            endcase
        end
    end

    // Holding buffer, ack and drain never fall in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (take) begin
            buf_valid <= 1'b1;
        end else if (!stall_if) begin
            buf_valid <= 1'b0;
        end
        if (take) begin
            buf_instr <= rsp_instr;
        end
    end

    assign wb_req.cyc = (state == S_REQ);
    assign wb_req.stb = (state == S_REQ);
    assign wb_req.adr = adr_q;

    // Fetch counts as ready once it holds a word
    assign ready           = buf_valid;
    assign fetch_out.valid = buf_valid;
    assign fetch_out.instr = buf_instr;

endmodule

//--- run.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb -f src.f -o pipe_sim \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/pipe_sim)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

//--- src.f
common/pipe_pkg.sv
src/stall_ctrl.sv
src/reg_file.sv
fetch/fetch_unit.sv
decode/decode_stage.sv
execute/exec_stage.sv
src/pipe_top.sv
bench/pipe_chk.sv
bench/pipe_tb.sv

//--- src/pipe_top.sv
// Top level of the three-stage pipeline: fetch, decode and execute
// Instructions come in over a read-only Wishbone classic port
// retire pulses once per instruction that writes a register
// halted stays high from the cycle after HALT leaves execute until reset
`timescale 1ns/1ps

module pipe_top
    import pipe_pkg::*;
#(
    parameter logic [IADR_W-1:0] FETCH_BASE = '0,
    parameter int                MUL_STEP   = 4
) (
    input  logic    clk,
    input  logic    rst,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output retire_t retire,
    output logic    halted
);

    logic [NUM_STAGES-1:0] stage_ready;
    logic [NUM_STAGES-1:0] hazard;
    logic [NUM_STAGES-1:0] stage_stall;
    logic                  if_ready;
    logic                  ex_ready;
    logic                  id_hazard;
    fetch_out_t            fetch_out;
    dec_out_t              dec_out;
    dest_t                 ex_dest;

    // Decode is always ready, only its hazard can hold it
    assign stage_ready = {ex_ready, 1'b1, if_ready};
    assign hazard      = {1'b0, id_hazard, 1'b0};

    stall_ctrl u_stall_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stage_ready (stage_ready),
        .hazard      (hazard),
        .stage_stall (stage_stall)
    );

    fetch_unit #(.FETCH_BASE(FETCH_BASE)) u_fetch (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .stall_if  (stage_stall[STAGE_IF]),
        .id_stall  (stage_stall[STAGE_ID]),
        .ready     (if_ready),
        .fetch_out (fetch_out)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .fetch_in (fetch_out),
        .stall_if (stage_stall[STAGE_IF]),
        .stall_id (stage_stall[STAGE_ID]),
        .ex_dest  (ex_dest),
        .wr       (retire),
        .dec_out  (dec_out),
        .hazard   (id_hazard)
    );

    exec_stage #(.MUL_STEP(MUL_STEP)) u_exec (
        .clk      (clk),
        .rst      (rst),
        .dec_in   (dec_out),
        .stall_id (stage_stall[STAGE_ID]),
        .stall_ex (stage_stall[STAGE_EX]),
        .ready    (ex_ready),
        .ex_dest  (ex_dest),
        .retire   (retire),
        .halted   (halted)
    );

endmodule

//--- src/reg_file.sv
// Eight-entry register file, two read ports and one write port
// Reads are combinational; a read of the entry being written sees the new value
// No reset of its own, cleared through the write port during reset
`timescale 1ns/1ps

module reg_file
    import pipe_pkg::*;
(
    input  logic            clk,
    input  reg_idx_t        rs1,
    input  reg_idx_t        rs2,
    output logic [XLEN-1:0] rd1,
    output logic [XLEN-1:0] rd2,
    input  retire_t         wr
);

    localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            regs[wr.rd] <= wr.value;
        end
    end

    // Write-through bypass, the only forwarding path in the pipeline
    assign rd1 = (wr.valid && wr.rd == rs1) ? wr.value : regs[rs1];
    assign rd2 = (wr.valid && wr.rd == rs2) ? wr.value : regs[rs2];

endmodule

//--- src/stall_ctrl.sv
// Stall controller for the three-stage pipeline
// Purely combinational; a stage stalls when it is not ready or has a hazard
// Stalls propagate backward so no stage overwrites a held one
// clk and rst only serve the bound assertion checker
`timescale 1ns/1ps

module stall_ctrl
    import pipe_pkg::*;
(
    // Used by the bound checker only
    input  logic                  clk,
    input  logic                  rst,

    input  logic [NUM_STAGES-1:0] stage_ready,
    input  logic [NUM_STAGES-1:0] hazard,
    output logic [NUM_STAGES-1:0] stage_stall
);

    // Stall that a stage raises on its own
    logic [NUM_STAGES-1:0] direct_stall;

    // Hazards here are the ones that no forwarding path can resolve
    assign direct_stall = ~stage_ready | hazard;

    always_comb begin
        // Execute is last, so nothing behind it can hold it
        stage_stall[NUM_STAGES-1] = direct_stall[NUM_STAGES-1];

        // Every earlier stage also stalls when the one after it stalls
        for (int i = NUM_STAGES - 2; i >= 0; i--) begin
            stage_stall[i] = stage_stall[i+1] | direct_stall[i];
        end
    end

    // Examples with ID always ready:
    //   EX busy in a MUL     -> stall = 3'b111
    //   hazard in ID only    -> stall = 3'b011
    //   fetch buffer empty   -> stall = 3'b001

endmodule
